// ==== src/mem_pkg.sv ====
package mem_pkg;

  // One processor-bus word, data or address
  typedef logic [31:0] word_t;

  // One byte on the shared byte bus
  typedef logic [7:0] byte_t;

  // Access size, value is the byte count
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'd1,
    SIZE_HALF = 3'd2,
    SIZE_WORD = 3'd4
  } access_size_e;

  // Sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT
  } seq_state_e;

  // Byte-bus peers, encoding matches the region code for mapped peers
  typedef enum logic [1:0] {
    REG_BOOT,
    REG_VIDEO,
    REG_HEX,
    REG_NONE
  } region_e;

  // Address map
  localparam int REGION_LSB      = 12;
  localparam int REGION_BITS     = 4;
  localparam int BOOT_ADDR_BITS  = 12;
  localparam int VIDEO_ADDR_BITS = 10;
  localparam int HEX_ADDR_BITS   = 2;

endpackage

// ==== src/bus_sequencer.sv ====
module bus_sequencer (
  input  logic                  i_clk,
  input  logic                  i_reset,
  // Processor bus
  input  logic                  i_bus_dv,
  input  mem_pkg::word_t        i_bus_address,
  input  mem_pkg::word_t        i_bus_data,
  input  mem_pkg::access_size_e i_bus_size,
  input  logic                  i_bus_write,
  // Byte bus return path
  input  mem_pkg::byte_t        i_byte_rdata,
  input  logic                  i_byte_done,
  output logic                  o_busy,
  output logic                  o_bus_dv,
  output mem_pkg::word_t        o_bus_data,
  // Byte bus request path
  output logic                  o_byte_req,
  output mem_pkg::word_t        o_byte_addr,
  output mem_pkg::byte_t        o_byte_wdata,
  output logic                  o_byte_write
);

  mem_pkg::seq_state_e state_q;

  // Latched request
  mem_pkg::word_t addr_q;
  mem_pkg::word_t wdata_q;
  mem_pkg::word_t rdata_q;
  logic [2:0]     count_q;
  logic [1:0]     index_q;
  logic           write_q;
  logic           dv_q;

  logic accept;
  logic step;

  // New request only taken while idle
  assign accept = (state_q == mem_pkg::ST_IDLE) && i_bus_dv;
  // One byte finished
  assign step   = (state_q == mem_pkg::ST_WAIT) && i_byte_done;

  // Control FSM
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q <= mem_pkg::ST_IDLE;
      dv_q    <= 1'b0;
    end else begin
      dv_q <= 1'b0;
      case (state_q)
        mem_pkg::ST_IDLE: begin
          if (i_bus_dv) begin
            state_q <= mem_pkg::ST_ISSUE;
          end
        end
        // Request strobe lasts a single cycle
        mem_pkg::ST_ISSUE: begin
          state_q <= mem_pkg::ST_WAIT;
        end
        mem_pkg::ST_WAIT: begin
          if (i_byte_done) begin
            // Last byte, complete the bus access
            if (count_q <= 3'd1) begin
              state_q <= mem_pkg::ST_IDLE;
              dv_q    <= 1'b1;
            end else begin
              state_q <= mem_pkg::ST_ISSUE;
            end
          end
        end
        default: begin
          state_q <= mem_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Address, data and byte counters
  always_ff @(posedge i_clk) begin
    if (accept) begin
      addr_q  <= i_bus_address;
      wdata_q <= i_bus_data;
      // Zero so narrow reads and all writes return zero-extended data
      rdata_q <= '0;
      count_q <= i_bus_size;
      index_q <= '0;
      write_q <= i_bus_write;
    end else if (step) begin
      // Little-endian walk, next byte at next address
      addr_q  <= addr_q + 32'd1;
      wdata_q <= {8'h00, wdata_q[31:8]};
      if (!write_q) begin
        rdata_q[{index_q, 3'b000} +: 8] <= i_byte_rdata;
      end
      count_q <= count_q - 3'd1;
      index_q <= index_q + 2'd1;
    end
  end

  assign o_busy       = (state_q != mem_pkg::ST_IDLE);
  assign o_bus_dv     = dv_q;
  assign o_bus_data   = rdata_q;
  assign o_byte_req   = (state_q == mem_pkg::ST_ISSUE);
  assign o_byte_addr  = addr_q;
  // Current write byte always sits in the low lane
  assign o_byte_wdata = wdata_q[7:0];
  assign o_byte_write = write_q;

endmodule

// ==== src/region_decoder.sv ====
module region_decoder (
  input  logic           i_clk,
  input  logic           i_reset,
  input  mem_pkg::word_t i_byte_addr,
  input  logic           i_byte_req,
  input  mem_pkg::byte_t i_boot_rdata,
  input  mem_pkg::byte_t i_video_rdata,
  input  mem_pkg::byte_t i_hex_rdata,
  input  logic           i_boot_done,
  input  logic           i_video_done,
  input  logic           i_hex_done,
  output logic           o_boot_req,
  output logic           o_video_req,
  output logic           o_hex_req,
  output mem_pkg::byte_t o_byte_rdata,
  output logic           o_byte_done
);

  mem_pkg::region_e                region;
  logic [mem_pkg::REGION_BITS-1:0] region_code;
  logic                            high_bits;
  logic                            none_done_q;

  assign region_code = i_byte_addr[mem_pkg::REGION_LSB +: mem_pkg::REGION_BITS];
  // Anything above the region field means unmapped
  assign high_bits   = |i_byte_addr[31:mem_pkg::REGION_LSB + mem_pkg::REGION_BITS];

  always_comb begin
    region = mem_pkg::REG_NONE;
    if (!high_bits) begin
      case (int'(region_code))
        0:       region = mem_pkg::REG_BOOT;
        1:       region = mem_pkg::REG_VIDEO;
        2:       region = mem_pkg::REG_HEX;
        default: region = mem_pkg::REG_NONE;
      endcase
    end
  end

  // Only the selected peer sees the strobe
  assign o_boot_req  = i_byte_req && (region == mem_pkg::REG_BOOT);
  assign o_video_req = i_byte_req && (region == mem_pkg::REG_VIDEO);
  assign o_hex_req   = i_byte_req && (region == mem_pkg::REG_HEX);

  // Stand-in peer for unmapped space, keeps the sequencer from hanging
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      none_done_q <= 1'b0;
    end else begin
      none_done_q <= i_byte_req && (region == mem_pkg::REG_NONE);
    end
  end

  // Address holds through the done cycle so region still selects the right peer
  always_comb begin
    case (region)
      mem_pkg::REG_BOOT: begin
        o_byte_rdata = i_boot_rdata;
        o_byte_done  = i_boot_done;
      end
      mem_pkg::REG_VIDEO: begin
        o_byte_rdata = i_video_rdata;
        o_byte_done  = i_video_done;
      end
      mem_pkg::REG_HEX: begin
        o_byte_rdata = i_hex_rdata;
        o_byte_done  = i_hex_done;
      end
      default: begin
        o_byte_rdata = '0;
        o_byte_done  = none_done_q;
      end
    endcase
  end

endmodule

// ==== src/byte_ram.sv ====
module byte_ram #(
  parameter int ADDR_BITS = mem_pkg::BOOT_ADDR_BITS
) (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_req,
  input  logic                 i_write,
  input  logic [ADDR_BITS-1:0] i_addr,
  input  mem_pkg::byte_t       i_wdata,
  output mem_pkg::byte_t       o_rdata,
  output logic                 o_done
);

  mem_pkg::byte_t mem [2**ADDR_BITS];
  mem_pkg::byte_t rdata_q;
  logic           done_q;

  // Single port, write or registered read
  always_ff @(posedge i_clk) begin
    if (i_req) begin
      if (i_write) begin
        mem[i_addr] <= i_wdata;
      end else begin
        rdata_q <= mem[i_addr];
      end
    end
  end

  // Done one cycle after every request
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      done_q <= 1'b0;
    end else begin
      done_q <= i_req;
    end
  end

  assign o_rdata = rdata_q;
  assign o_done  = done_q;

endmodule

// ==== src/video_ram.sv ====
module video_ram (
  input  logic                               i_clk,
  input  logic                               i_reset,
  // Port A, byte bus side
  input  logic                               i_req,
  input  logic                               i_write,
  input  logic [mem_pkg::VIDEO_ADDR_BITS-1:0] i_addr,
  input  mem_pkg::byte_t                     i_wdata,
  output mem_pkg::byte_t                     o_rdata,
  output logic                               o_done,
  // Port B, display side
  input  logic [mem_pkg::VIDEO_ADDR_BITS-1:0] i_video_address,
  output mem_pkg::byte_t                     o_video_data
);

  mem_pkg::byte_t mem [2**mem_pkg::VIDEO_ADDR_BITS];
  mem_pkg::byte_t rdata_q;
  mem_pkg::byte_t video_q;
  logic           done_q;

  // Port A read/write
  always_ff @(posedge i_clk) begin
    if (i_req) begin
      if (i_write) begin
        mem[i_addr] <= i_wdata;
      end else begin
        rdata_q <= mem[i_addr];
      end
    end
  end

  // Port B, free-running read, fixed one-cycle latency
  // Old data returned on a same-cycle write to this address
  always_ff @(posedge i_clk) begin
    video_q <= mem[i_video_address];
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      done_q <= 1'b0;
    end else begin
      done_q <= i_req;
    end
  end

  assign o_rdata      = rdata_q;
  assign o_done       = done_q;
  assign o_video_data = video_q;

endmodule

// ==== src/hex_regs.sv ====
module hex_regs (
  input  logic                             i_clk,
  input  logic                             i_reset,
  input  logic                             i_req,
  input  logic                             i_write,
  input  logic [mem_pkg::HEX_ADDR_BITS-1:0] i_addr,
  input  mem_pkg::byte_t                   i_wdata,
  output mem_pkg::byte_t                   o_rdata,
  output logic                             o_done,
  output mem_pkg::word_t                   o_hex
);

  // One byte per display pair
  mem_pkg::byte_t regs_q [2**mem_pkg::HEX_ADDR_BITS];
  mem_pkg::byte_t rdata_q;
  logic           done_q;

  // Display blank after reset
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int k = 0; k < 2**mem_pkg::HEX_ADDR_BITS; k++) begin
        regs_q[k] <= '0;
      end
      done_q <= 1'b0;
    end else begin
      done_q <= i_req;
      if (i_req && i_write) begin
        regs_q[i_addr] <= i_wdata;
      end
    end
  end

  // Readback
  always_ff @(posedge i_clk) begin
    if (i_req && !i_write) begin
      rdata_q <= regs_q[i_addr];
    end
  end

  assign o_rdata = rdata_q;
  assign o_done  = done_q;
  // Register k on bits 8k+7..8k
  assign o_hex   = {regs_q[3], regs_q[2], regs_q[1], regs_q[0]};

endmodule

// ==== src/memory_top.sv ====
module memory_top (
  input  logic                               i_clk,
  input  logic                               i_reset,
  // Processor bus
  input  logic                               i_bus_dv,
  input  mem_pkg::word_t                     i_bus_address,
  input  mem_pkg::word_t                     i_bus_data,
  input  mem_pkg::access_size_e              i_bus_size,
  input  logic                               i_bus_write,
  output logic                               o_busy,
  output logic                               o_bus_dv,
  output mem_pkg::word_t                     o_bus_data,
  // Display read port
  input  logic [mem_pkg::VIDEO_ADDR_BITS-1:0] i_video_address,
  output mem_pkg::byte_t                     o_video_data,
  output mem_pkg::word_t                     o_hex
);

  // Shared byte bus
  logic           byte_req;
  mem_pkg::word_t byte_addr;
  mem_pkg::byte_t byte_wdata;
  logic           byte_write;
  mem_pkg::byte_t byte_rdata;
  logic           byte_done;

  // Per-peer strobes and returns
  logic           boot_req;
  logic           video_req;
  logic           hex_req;
  mem_pkg::byte_t boot_rdata;
  mem_pkg::byte_t video_rdata;
  mem_pkg::byte_t hex_rdata;
  logic           boot_done;
  logic           video_done;
  logic           hex_done;

  bus_sequencer u_bus_sequencer (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_bus_dv      (i_bus_dv),
    .i_bus_address (i_bus_address),
    .i_bus_data    (i_bus_data),
    .i_bus_size    (i_bus_size),
    .i_bus_write   (i_bus_write),
    .i_byte_rdata  (byte_rdata),
    .i_byte_done   (byte_done),
    .o_busy        (o_busy),
    .o_bus_dv      (o_bus_dv),
    .o_bus_data    (o_bus_data),
    .o_byte_req    (byte_req),
    .o_byte_addr   (byte_addr),
    .o_byte_wdata  (byte_wdata),
    .o_byte_write  (byte_write)
  );

  region_decoder u_region_decoder (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_byte_addr   (byte_addr),
    .i_byte_req    (byte_req),
    .i_boot_rdata  (boot_rdata),
    .i_video_rdata (video_rdata),
    .i_hex_rdata   (hex_rdata),
    .i_boot_done   (boot_done),
    .i_video_done  (video_done),
    .i_hex_done    (hex_done),
    .o_boot_req    (boot_req),
    .o_video_req   (video_req),
    .o_hex_req     (hex_req),
    .o_byte_rdata  (byte_rdata),
    .o_byte_done   (byte_done)
  );

  // Boot RAM, 4 KiB
  byte_ram #(
    .ADDR_BITS (mem_pkg::BOOT_ADDR_BITS)
  ) u_boot_ram (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_req   (boot_req),
    .i_write (byte_write),
    .i_addr  (byte_addr[mem_pkg::BOOT_ADDR_BITS-1:0]),
    .i_wdata (byte_wdata),
    .o_rdata (boot_rdata),
    .o_done  (boot_done)
  );

  // Video RAM, upper offset bits alias
  video_ram u_video_ram (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_req           (video_req),
    .i_write         (byte_write),
    .i_addr          (byte_addr[mem_pkg::VIDEO_ADDR_BITS-1:0]),
    .i_wdata         (byte_wdata),
    .o_rdata         (video_rdata),
    .o_done          (video_done),
    .i_video_address (i_video_address),
    .o_video_data    (o_video_data)
  );

  hex_regs u_hex_regs (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_req   (hex_req),
    .i_write (byte_write),
    .i_addr  (byte_addr[mem_pkg::HEX_ADDR_BITS-1:0]),
    .i_wdata (byte_wdata),
    .o_rdata (hex_rdata),
    .o_done  (hex_done),
    .o_hex   (o_hex)
  );

endmodule

// ==== tb/memory_checker.sv ====
module memory_checker (
  input logic i_clk,
  input logic i_reset,
  input logic i_boot_req,
  input logic i_video_req,
  input logic i_hex_req,
  input logic i_byte_req,
  input logic i_byte_done,
  input logic i_busy,
  input logic i_bus_dv
);

  // Tally of failed assertions, read by the testbench summary
  int failures = 0;

  // Decoder gates the strobe to one peer at most
  assert property (@(posedge i_clk) disable iff (i_reset)
    $onehot0({i_boot_req, i_video_req, i_hex_req}))
    else begin
      $error("more than one peer request in the same cycle");
      failures = failures + 1;
    end

  // Completion is a single-cycle pulse
  assert property (@(posedge i_clk) disable iff (i_reset)
    i_bus_dv |=> !i_bus_dv)
    else begin
      $error("bus completion pulse longer than one cycle");
      failures = failures + 1;
    end

  // Every byte request answered on the next cycle, unmapped ones too
  assert property (@(posedge i_clk) disable iff (i_reset)
    i_byte_req |=> i_byte_done)
    else begin
      $error("byte request without a done one cycle later");
      failures = failures + 1;
    end

  // Sequencer idle straight out of reset
  assert property (@(posedge i_clk)
    i_reset |=> !i_busy)
    else begin
      $error("busy high in the cycle after reset");
      failures = failures + 1;
    end

endmodule

bind memory_top memory_checker u_memory_checker (
  .i_clk       (i_clk),
  .i_reset     (i_reset),
  .i_boot_req  (boot_req),
  .i_video_req (video_req),
  .i_hex_req   (hex_req),
  .i_byte_req  (byte_req),
  .i_byte_done (byte_done),
  .i_busy      (o_busy),
  .i_bus_dv    (o_bus_dv)
);

// ==== tb/tb_memory_top.sv ====
module tb_memory_top;

  logic                                i_clk;
  logic                                i_reset;
  logic                                i_bus_dv;
  mem_pkg::word_t                      i_bus_address;
  mem_pkg::word_t                      i_bus_data;
  mem_pkg::access_size_e               i_bus_size;
  logic                                i_bus_write;
  logic                                o_busy;
  logic                                o_bus_dv;
  mem_pkg::word_t                      o_bus_data;
  logic [mem_pkg::VIDEO_ADDR_BITS-1:0] i_video_address;
  mem_pkg::byte_t                      o_video_data;
  mem_pkg::word_t                      o_hex;

  // Reference model with a written flag per byte
  mem_pkg::byte_t        boot_mem  [4096];
  logic                  boot_wr   [4096];
  mem_pkg::byte_t        video_mem [1024];
  logic                  video_wr  [1024];
  mem_pkg::byte_t        hex_mem   [4];
  logic                  hex_wr    [4];
  // Video offsets written so far for display probes
  int                    video_seen [$];
  // Boot write history replayed as reads
  mem_pkg::word_t        boot_starts [$];
  mem_pkg::access_size_e boot_sizes  [$];

  int error_count;
  int timeout_count;

  memory_top i_memory_top (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_bus_dv        (i_bus_dv),
    .i_bus_address   (i_bus_address),
    .i_bus_data      (i_bus_data),
    .i_bus_size      (i_bus_size),
    .i_bus_write     (i_bus_write),
    .o_busy          (o_busy),
    .o_bus_dv        (o_bus_dv),
    .o_bus_data      (o_bus_data),
    .i_video_address (i_video_address),
    .o_video_data    (o_video_data),
    .o_hex           (o_hex)
  );

  initial begin
    i_clk = 1'b0;
    forever begin
      #50 i_clk = ~i_clk;
    end
  end

  task automatic check_word(input string name, input mem_pkg::word_t exp,
                            input mem_pkg::word_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_byte(input string name, input mem_pkg::byte_t exp,
                            input mem_pkg::byte_t act);
    if (act !== exp) begin
      $display("error %s expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s expected %b actual %b", name, exp, act);
      error_count++;
    end
  endtask

  // Region from bits 15..12 when bits 31..16 are zero
  function automatic mem_pkg::region_e region_of(input mem_pkg::word_t addr);
    if (addr[31:16] != 16'h0000) begin
      return mem_pkg::REG_NONE;
    end
    case (addr[15:12])
      4'h0:    return mem_pkg::REG_BOOT;
      4'h1:    return mem_pkg::REG_VIDEO;
      4'h2:    return mem_pkg::REG_HEX;
      default: return mem_pkg::REG_NONE;
    endcase
  endfunction

  function automatic void model_store(input mem_pkg::word_t addr, input mem_pkg::byte_t data);
    case (region_of(addr))
      mem_pkg::REG_BOOT: begin
        boot_mem[addr[11:0]] = data;
        boot_wr[addr[11:0]]  = 1'b1;
      end
      mem_pkg::REG_VIDEO: begin
        // Offset bits above 9 alias
        video_mem[addr[9:0]] = data;
        video_wr[addr[9:0]]  = 1'b1;
        video_seen.push_back(int'(addr[9:0]));
      end
      mem_pkg::REG_HEX: begin
        hex_mem[addr[1:0]] = data;
      end
      default: begin
        // Unmapped writes vanish
      end
    endcase
  endfunction

  function automatic mem_pkg::byte_t model_fetch(input mem_pkg::word_t addr,
                                                 output logic known);
    case (region_of(addr))
      mem_pkg::REG_BOOT: begin
        known = boot_wr[addr[11:0]];
        return boot_mem[addr[11:0]];
      end
      mem_pkg::REG_VIDEO: begin
        known = video_wr[addr[9:0]];
        return video_mem[addr[9:0]];
      end
      mem_pkg::REG_HEX: begin
        known = hex_wr[addr[1:0]];
        return hex_mem[addr[1:0]];
      end
      default: begin
        known = 1'b1;
        return 8'h00;
      end
    endcase
  endfunction

  // Register k lands in byte lane k of the display word
  function automatic mem_pkg::word_t hex_word();
    mem_pkg::word_t display;
    display = '0;
    for (int k = 0; k < 4; k++) begin
      display[8*k +: 8] = hex_mem[k];
    end
    return display;
  endfunction

  function automatic mem_pkg::access_size_e pick_size();
    case ($urandom_range(0, 2))
      0:       return mem_pkg::SIZE_BYTE;
      1:       return mem_pkg::SIZE_HALF;
      default: return mem_pkg::SIZE_WORD;
    endcase
  endfunction

  // Either a high-bit address or a free region code 3..15
  function automatic mem_pkg::word_t unmapped_addr();
    if ($urandom_range(0, 1) == 0) begin
      return $urandom() | 32'h0001_0000;
    end
    return 32'h0000_3000 + $urandom_range(0, 32'h0000_cfff);
  endfunction

  // One strobe and a wait for the completion pulse
  task automatic bus_access(input mem_pkg::word_t addr, input mem_pkg::word_t data,
                            input mem_pkg::access_size_e size, input logic write,
                            output mem_pkg::word_t rdata);
    int cycles;
    rdata = '0;
    cycles = 0;
    @(negedge i_clk);
    i_bus_dv      = 1'b1;
    i_bus_address = addr;
    i_bus_data    = data;
    i_bus_size    = size;
    i_bus_write   = write;
    @(negedge i_clk);
    i_bus_dv = 1'b0;
    // Accepted on the last edge
    check_bit("busy during access", 1'b1, o_busy);
    while (!o_bus_dv && cycles < 200) begin
      @(negedge i_clk);
      cycles++;
    end
    if (o_bus_dv) begin
      rdata = o_bus_data;
      check_bit("busy at completion", 1'b0, o_busy);
    end else begin
      $display("timeout, no bus completion within 200 cycles for address %h", addr);
      timeout_count++;
    end
  endtask

  // Little-endian with data starting at bits 7..0
  task automatic write_bytes(input string name, input mem_pkg::word_t addr,
                             input mem_pkg::word_t data, input mem_pkg::access_size_e size);
    mem_pkg::word_t act;
    bus_access(addr, data, size, 1'b1, act);
    for (int i = 0; i < int'(size); i++) begin
      model_store(addr + i, data[8*i +: 8]);
    end
    check_word(name, 32'h0000_0000, act);
  endtask

  // Unwritten bytes masked out while lanes above the size must read zero
  task automatic read_and_compare(input string name, input mem_pkg::word_t addr,
                                  input mem_pkg::access_size_e size);
    mem_pkg::word_t exp;
    mem_pkg::word_t mask;
    mem_pkg::word_t act;
    mem_pkg::byte_t value;
    logic           known;
    exp  = '0;
    mask = '1;
    for (int i = 0; i < int'(size); i++) begin
      value = model_fetch(addr + i, known);
      if (known) begin
        exp[8*i +: 8] = value;
      end else begin
        mask[8*i +: 8] = 8'h00;
      end
    end
    bus_access(addr, '0, size, 1'b0, act);
    check_word(name, exp, act & mask);
  endtask

  // Display port answers one cycle after the address
  task automatic probe_display(input int idx);
    @(negedge i_clk);
    i_video_address = idx[9:0];
    @(negedge i_clk);
    check_byte("video display port", video_mem[idx], o_video_data);
  endtask

  initial begin
    mem_pkg::word_t addr;
    mem_pkg::word_t edges [4];
    int             pick;
    int             total;
    void'($urandom(32'hdb18));
    i_reset         = 1'b1;
    i_bus_dv        = 1'b0;
    i_bus_address   = '0;
    i_bus_data      = '0;
    i_bus_size      = mem_pkg::SIZE_BYTE;
    i_bus_write     = 1'b0;
    i_video_address = '0;
    error_count     = 0;
    timeout_count   = 0;
    for (int i = 0; i < 4096; i++) begin
      boot_wr[i] = 1'b0;
    end
    for (int i = 0; i < 1024; i++) begin
      video_wr[i] = 1'b0;
    end
    // Hex registers come out of reset as zero
    for (int i = 0; i < 4; i++) begin
      hex_mem[i] = 8'h00;
      hex_wr[i]  = 1'b1;
    end
    repeat (16) @(negedge i_clk);
    i_reset = 1'b0;
    @(negedge i_clk);
    check_bit("reset busy", 1'b0, o_busy);
    check_bit("reset bus dv", 1'b0, o_bus_dv);
    check_word("reset hex output", 32'h0000_0000, o_hex);

    // Boot RAM writes at random sizes and start addresses replayed as reads
    repeat (60) begin
      addr = $urandom_range(0, 4095);
      boot_starts.push_back(addr);
      boot_sizes.push_back(pick_size());
      write_bytes("boot write", addr, $urandom(), boot_sizes[$]);
    end
    repeat (60) begin
      pick = $urandom_range(0, boot_starts.size() - 1);
      read_and_compare("boot read", boot_starts[pick], boot_sizes[pick]);
    end

    // Video writes over the whole aliased 4 KiB window
    repeat (40) begin
      addr = 32'h0000_1000 + $urandom_range(0, 4095);
      write_bytes("video write", addr, $urandom(), pick_size());
    end
    repeat (30) begin
      pick = video_seen[$urandom_range(0, video_seen.size() - 1)];
      probe_display(pick);
    end
    repeat (10) begin
      pick = video_seen[$urandom_range(0, video_seen.size() - 1)];
      read_and_compare("video read", 32'h0000_1000 + pick, mem_pkg::SIZE_BYTE);
    end

    // Display word checked after each hex write
    repeat (12) begin
      addr = 32'h0000_2000 + $urandom_range(0, 4095);
      write_bytes("hex write", addr, $urandom(), pick_size());
      check_word("hex output", hex_word(), o_hex);
    end
    read_and_compare("hex read", 32'h0000_2000, mem_pkg::SIZE_WORD);
    read_and_compare("hex alias read", 32'h0000_2ffc, mem_pkg::SIZE_WORD);

    // Neighbours written before and read after unmapped traffic
    write_bytes("boot edge write", 32'h0000_0ffc, $urandom(), mem_pkg::SIZE_WORD);
    write_bytes("video edge write", 32'h0000_1ffc, $urandom(), mem_pkg::SIZE_WORD);
    write_bytes("hex edge write", 32'h0000_2ffc, $urandom(), mem_pkg::SIZE_WORD);
    repeat (20) begin
      addr = unmapped_addr();
      read_and_compare("unmapped read", addr, pick_size());
      write_bytes("unmapped write", addr, $urandom(), pick_size());
    end
    write_bytes("unmapped edge write", 32'h0000_3000, $urandom(), mem_pkg::SIZE_WORD);
    read_and_compare("boot neighbour read", 32'h0000_0ffc, mem_pkg::SIZE_WORD);
    read_and_compare("video neighbour read", 32'h0000_1ffc, mem_pkg::SIZE_WORD);
    read_and_compare("hex neighbour read", 32'h0000_2ffc, mem_pkg::SIZE_WORD);
    check_word("hex output after unmapped", hex_word(), o_hex);

    // Words across each region boundary
    edges = '{32'h0000_0ffe, 32'h0000_1ffe, 32'h0000_2ffe, 32'h0000_fffe};
    for (int i = 0; i < 4; i++) begin
      write_bytes("straddle write", edges[i], $urandom(), mem_pkg::SIZE_WORD);
      read_and_compare("straddle read", edges[i], mem_pkg::SIZE_WORD);
    end
    probe_display(1023);
    check_word("hex output after straddle", hex_word(), o_hex);

    total = error_count + timeout_count + i_memory_top.u_memory_checker.failures;
    $display("errors %0d, timeouts %0d, assertion failures %0d", error_count,
             timeout_count, i_memory_top.u_memory_checker.failures);
    if (total == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
src/mem_pkg.sv
src/bus_sequencer.sv
src/region_decoder.sv
src/byte_ram.sv
src/video_ram.sv
src/hex_regs.sv
src/memory_top.sv
tb/memory_checker.sv
tb/tb_memory_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_memory_top \
  -f project.f -o sim_memory_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion errors so the summary line is printed
./obj_dir/sim_memory_top +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
fi
exit 1
